// ==== soc_ctrl.f ====
design/soc_ctrl_pkg.sv
design/periph_bus_demux.sv
design/clint_regs.sv
design/clint_timer.sv
design/debug_ctrl.sv
design/soc_ctrl_top.sv
sim/tb_soc_ctrl.sv

// ==== sim/soc_ctrl_stim.txt ====
# columns: name op arg1 arg2 arg3, all numbers hex
# wr rd = addr data err, rtc = cycles level, idle = cycles, tirq ipi dbg = unused harts
reset_irq    tirq 0        0        0
reset_ipi    ipi  0        0        0
reset_dbg    dbg  0        0        0
dbg_wr       wr   00000000 00000005 0
dbg_early    dbg  0        0        0
dbg_rd       rd   00000000 00000005 0
dbg_wait_a   idle 189      0        0
dbg_at_400   dbg  0        0        0
dbg_wait_b   idle c8       0        0
dbg_at_600   dbg  0        5        0
dbg_rd_late  rd   00000000 00000005 0
bad_rd       rd   10000000 00000000 1
bad_wr       wr   10000000 deadbeef 1
past_dbg     rd   00001000 00000000 1
past_clint   rd   02010000 00000000 1
unused_clint rd   02000100 00000000 0
unused_dbg   rd   00000004 00000000 0
msip1_wr     wr   02000004 00000001 0
ipi_h1       ipi  0        2        0
msip1_rd     rd   02000004 00000001 0
msip3_wr     wr   0200000c ffffffff 0
ipi_h1_h3    ipi  0        a        0
msip1_clr    wr   02000004 00000000 0
ipi_h3       ipi  0        8        0
cmp0_lo      wr   02004000 00000100 0
cmp0_hi      wr   02004004 00000000 0
cmp1_lo      wr   02004008 00000200 0
cmp1_hi      wr   0200400c 00000000 0
cmp2_lo      wr   02004010 00000180 0
cmp2_hi      wr   02004014 00000000 0
tirq_none    tirq 0        0        0
mtime_lo_wr  wr   0200bff8 00000180 0
mtime_hi_wr  wr   0200bffc 00000000 0
tirq_mid     tirq 0        5        0
cmp0_lo_rd   rd   02004000 00000100 0
cmp3_hi_rd   rd   0200401c ffffffff 0
mtime_lo_rd  rd   0200bff8 00000180 0
mtime_hi_rd  rd   0200bffc 00000000 0
rtc_p0_hi    rtc  3        1        0
rtc_p0_lo    rtc  3        0        0
rtc_p1_hi    rtc  3        1        0
rtc_p1_lo    rtc  3        0        0
rtc_p2_hi    rtc  3        1        0
rtc_p2_lo    rtc  3        0        0
rtc_p3_hi    rtc  3        1        0
rtc_p3_lo    rtc  3        0        0
rtc_settle   idle 4        0        0
mtime_div_rd rd   0200bff8 00000182 0
tirq_after   tirq 0        5        0

// ==== sim/tb_soc_ctrl.sv ====
/*
 * testbench of the soc control block, runs the operations listed in the
 * stimulus file against the DUT and checks every response and output
 */
`timescale 1ns/10ps

module tb_soc_ctrl
  import soc_ctrl_pkg::*;
();

  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 8;

  typedef logic [8*24-1:0] name_t;
  typedef logic [8*8-1:0]  op_t;

  logic      clk_i;
  logic      ndmreset_n;
  logic      rtc_i;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  hart_vec_t timer_irq;
  hart_vec_t ipi;
  hart_vec_t debug_req;

  // one entry per stimulus line
  name_t     name_q [$];
  op_t       op_q [$];
  bus_data_t arg1_q [$];
  bus_data_t arg2_q [$];
  bus_data_t arg3_q [$];

  // responses still owed by the DUT
  name_t     pend_name_q [$];
  bus_rsp_t  pend_rsp_q [$];

  int unsigned n_mismatch;
  int unsigned n_other;
  logic        strobe_seen;
  logic        loaded;

  soc_ctrl_top dut (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .rtc_i       ( rtc_i      ),
    .bus_req_i   ( bus_req    ),
    .bus_rsp_o   ( bus_rsp    ),
    .timer_irq_o ( timer_irq  ),
    .ipi_o       ( ipi        ),
    .debug_req_o ( debug_req  )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_rsp(input name_t nm, input bus_rsp_t exp, input bus_rsp_t act);
    if (act.err !== exp.err) begin
      $display("MISMATCH %0s: expected err=%b, actual err=%b", nm, exp.err, act.err);
      n_mismatch++;
    end
  endtask

  task automatic check_data(input name_t nm, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      $display("MISMATCH %0s: expected rdata %h, actual %h", nm, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic check_harts(input name_t nm, input op_t kind, input hart_vec_t exp,
                             input hart_vec_t act);
    if (act !== exp) begin
      $display("MISMATCH %0s: expected %0s %b, actual %b", nm, kind, exp, act);
      n_mismatch++;
    end
  endtask

  // ----------------------------------------
  // response monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    strobe_seen <= bus_req.valid; // strobe the DUT takes on this edge
  end

  always @(negedge clk_i) begin : rsp_monitor
    name_t    nm;
    bus_rsp_t exp;
    if (strobe_seen === 1'b1 && pend_rsp_q.size() != 0) begin
      nm  = pend_name_q.pop_front();
      exp = pend_rsp_q.pop_front();
      if (bus_rsp.valid !== 1'b1) begin
        $display("no response pulse for %0s on the cycle after its strobe", nm);
        n_other++;
      end else begin
        check_rsp(nm, exp, bus_rsp);
        check_data(nm, exp.rdata, bus_rsp.rdata);
      end
    end else if (ndmreset_n === 1'b1 && bus_rsp.valid !== 1'b0) begin
      $display("response pulse seen without a strobe on the cycle before");
      n_other++;
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic load_stim();
    int               fd;
    int               cnt;
    logic [8*160-1:0] line;
    name_t            nm;
    op_t              op;
    bus_data_t        a1;
    bus_data_t        a2;
    bus_data_t        a3;
    fd = $fopen("sim/soc_ctrl_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file sim/soc_ctrl_stim.txt");
      n_other++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          cnt = $sscanf(line, "%s %s %h %h %h", nm, op, a1, a2, a3);
          if (cnt == 5 && nm != "#") begin // skips comments and blank lines
            name_q.push_back(nm);
            op_q.push_back(op);
            arg1_q.push_back(a1);
            arg2_q.push_back(a2);
            arg3_q.push_back(a3);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic bus_access(input name_t nm, input logic we, input bus_addr_t addr,
                            input bus_data_t wdata, input bus_data_t rdata_exp,
                            input logic err_exp);
    bus_req_t req;
    bus_rsp_t exp;
    req.valid = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    exp.valid = 1'b1;
    exp.err   = err_exp;
    exp.rdata = we ? '0 : rdata_exp; // writes answer with zero data
    @(posedge clk_i);
    bus_req <= req;
    pend_name_q.push_back(nm);
    pend_rsp_q.push_back(exp);
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      bus_req <= '0;
    end
  endtask

  task automatic hold_rtc(input int unsigned n, input logic level);
    @(posedge clk_i);
    bus_req <= '0;
    rtc_i   <= level;
    if (n > 1) begin
      repeat (n - 1) @(posedge clk_i);
    end
  endtask

  // one quiet cycle, then sample in the middle of it
  task automatic settle();
    @(posedge clk_i);
    bus_req <= '0;
    @(negedge clk_i);
  endtask

  task automatic run_op(input int unsigned i);
    name_t nm;
    op_t   op;
    nm = name_q[i];
    op = op_q[i];
    case (op)
      "wr":   bus_access(nm, 1'b1, arg1_q[i], arg2_q[i], '0, arg3_q[i][0]);
      "rd":   bus_access(nm, 1'b0, arg1_q[i], '0, arg2_q[i], arg3_q[i][0]);
      "rtc":  hold_rtc(arg1_q[i], arg2_q[i][0]);
      "idle": idle_cycles(arg1_q[i]);
      "tirq": begin
        settle();
        check_harts(nm, op, arg2_q[i][NrHarts-1:0], timer_irq);
      end
      "ipi": begin
        settle();
        check_harts(nm, op, arg2_q[i][NrHarts-1:0], ipi);
      end
      "dbg": begin
        settle();
        check_harts(nm, op, arg2_q[i][NrHarts-1:0], debug_req);
      end
      default: begin
        $display("unknown operation %0s on the stimulus line of %0s", op, nm);
        n_other++;
      end
    endcase
  endtask

  initial begin : main
    int unsigned i;
    bus_req     = '0;
    rtc_i       = 1'b0;
    ndmreset_n  = 1'b0;
    n_mismatch  = 0;
    n_other     = 0;
    strobe_seen = 1'b0;
    loaded      = 1'b0;
    load_stim();
    loaded = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    for (i = 0; i < name_q.size(); i++) begin
      run_op(i);
    end
    idle_cycles(3); // drains the last response
    if (pend_rsp_q.size() != 0) begin
      $display("%0d bus responses were never seen", pend_rsp_q.size());
      n_other += pend_rsp_q.size();
    end
    $display("%0d operations, %0d mismatches, %0d other errors",
             name_q.size(), n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned limit;
    wait (loaded === 1'b1);
    limit = name_q.size() * 20 + DmiDelCycles + 100;
    repeat (limit) @(posedge clk_i);
    $display("timeout, the stimulus did not finish within %0d clock periods", limit);
    $display("%0d mismatches, %0d other errors so far", n_mismatch, n_other);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== design/soc_ctrl_top.sv ====
/*
 * control corner of the four-hart subsystem: bus decoder, clint and
 * debug halt control, connected to the outside by one word bus
 */
`timescale 1ns/10ps

module soc_ctrl_top
  import soc_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      ndmreset_n,
  input  logic      rtc_i,
  input  bus_req_t  bus_req_i,
  output bus_rsp_t  bus_rsp_o,
  output hart_vec_t timer_irq_o,
  output hart_vec_t ipi_o,
  output hart_vec_t debug_req_o
);

  bus_req_t    clint_req;
  bus_req_t    dbg_req;
  bus_data_t   clint_rdata;
  bus_data_t   dbg_rdata;
  logic        tick;
  mtime_word_u mtime;
  mtime_word_u mtimecmp [NrHarts];

  // ----------------------------------------
  // bus decode
  // ----------------------------------------
  periph_bus_demux i_demux (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .bus_req_i     ( bus_req_i   ),
    .clint_rdata_i ( clint_rdata ),
    .dbg_rdata_i   ( dbg_rdata   ),
    .clint_req_o   ( clint_req   ),
    .dbg_req_o     ( dbg_req     ),
    .bus_rsp_o     ( bus_rsp_o   )
  );

  // ----------------------------------------
  // clint
  // ----------------------------------------
  clint_regs i_clint_regs (
    .clk_i      ( clk_i       ),
    .ndmreset_n ( ndmreset_n  ),
    .req_i      ( clint_req   ),
    .tick_i     ( tick        ),
    .rdata_o    ( clint_rdata ),
    .ipi_o      ( ipi_o       ),
    .mtime_o    ( mtime       ),
    .mtimecmp_o ( mtimecmp    )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .mtime_i     ( mtime       ),
    .mtimecmp_i  ( mtimecmp    ),
    .tick_o      ( tick        ),
    .timer_irq_o ( timer_irq_o )
  );

  // ----------------------------------------
  // debug
  // ----------------------------------------
  debug_ctrl i_debug_ctrl (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( dbg_req     ),
    .rdata_o     ( dbg_rdata   ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== design/debug_ctrl.sv ====
/*
 * per-hart halt-request register on the control bus, with a hold-off
 * counter that keeps debug_req_o low while the harts boot after reset
 */
`timescale 1ns/10ps

module debug_ctrl
  import soc_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      ndmreset_n,
  input  bus_req_t  req_i,
  output bus_data_t rdata_o,
  output hart_vec_t debug_req_o
);

  bus_addr_t          off;
  logic               sel;
  hart_vec_t          haltreq_q;
  logic [DmiCntW-1:0] del_cnt_q;

  assign off     = req_i.addr - DebugBase;
  assign sel     = (off == HaltreqOffset);
  assign rdata_o = sel ? {{(BusDw-NrHarts){1'b0}}, haltreq_q} : '0;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      haltreq_q <= '0;
    end else if (req_i.valid && req_i.we && sel) begin
      haltreq_q <= req_i.wdata[NrHarts-1:0]; // written whole
    end
  end

  // ----------------------------------------
  // post-reset hold-off
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      del_cnt_q <= DmiCntW'(DmiDelCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1; // sticks at zero
    end
  end

  assign debug_req_o = (del_cnt_q == '0) ? haltreq_q : '0;

endmodule

// ==== design/clint_timer.sv ====
/*
 * rtc synchronizer and divide-by-two tick generator for mtime, plus the
 * per-hart compare of mtime against mtimecmp that raises timer_irq_o
 */
`timescale 1ns/10ps

module clint_timer
  import soc_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        ndmreset_n,
  input  logic        rtc_i,
  input  mtime_word_u mtime_i,
  input  mtime_word_u mtimecmp_i [NrHarts],
  output logic        tick_o,
  output hart_vec_t   timer_irq_o
);

  logic [1:0] rtc_sync_q; // two-flop synchronizer
  logic       rtc_prev_q;
  logic       rtc_rise;
  logic       div_q;      // rtc halved
  logic       div_prev_q;

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // ----------------------------------------
  // rtc sync and divide
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      div_q      <= 1'b0;
      div_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      div_prev_q <= div_q;
      if (rtc_rise) begin
        div_q <= ~div_q;
      end
    end
  end

  assign tick_o = div_q & ~div_prev_q; // one pulse per two rtc periods

  // level irq, mtime at or past the hart's compare value
  always_comb begin
    for (int h = 0; h < NrHarts; h++) begin
      timer_irq_o[h] = (mtime_i.cnt >= mtimecmp_i[h].cnt);
    end
  end

endmodule

// ==== design/clint_regs.sv ====
/*
 * clint register file with per-hart msip and mtimecmp and the shared
 * mtime counter, all 32-bit word accessible over the control bus
 */
`timescale 1ns/10ps

module clint_regs
  import soc_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        ndmreset_n,
  input  bus_req_t    req_i,
  input  logic        tick_i,
  output bus_data_t   rdata_o,
  output hart_vec_t   ipi_o,
  output mtime_word_u mtime_o,
  output mtime_word_u mtimecmp_o [NrHarts]
);

  bus_addr_t   off;
  logic        wr;
  logic        mtime_lo_wr;
  logic        mtime_hi_wr;
  hart_vec_t   msip_q;
  mtime_word_u mtime_d;
  mtime_word_u mtime_q;
  mtime_word_u mtimecmp_q [NrHarts];

  assign off         = req_i.addr - ClintBase; // offset inside the region
  assign wr          = req_i.valid & req_i.we;
  assign mtime_lo_wr = wr && (off == MtimeOffset);
  assign mtime_hi_wr = wr && (off == MtimeOffset + 32'd4);

  // ----------------------------------------
  // read mux
  // ----------------------------------------
  always_comb begin
    rdata_o = '0;
    for (int h = 0; h < NrHarts; h++) begin
      if (off == MsipOffset + bus_addr_t'(4 * h)) begin
        rdata_o = {{(BusDw-1){1'b0}}, msip_q[h]};
      end
      if (off == MtimecmpOffset + bus_addr_t'(8 * h)) begin
        rdata_o = mtimecmp_q[h].w.lo;
      end
      if (off == MtimecmpOffset + bus_addr_t'(8 * h + 4)) begin
        rdata_o = mtimecmp_q[h].w.hi;
      end
    end
    if (off == MtimeOffset) begin
      rdata_o = mtime_q.w.lo;
    end
    if (off == MtimeOffset + 32'd4) begin
      rdata_o = mtime_q.w.hi;
    end
  end

  // ----------------------------------------
  // msip and mtimecmp
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q <= '0;
      for (int h = 0; h < NrHarts; h++) begin
        mtimecmp_q[h] <= '1; // no timer irq out of reset
      end
    end else if (wr) begin
      for (int h = 0; h < NrHarts; h++) begin
        if (off == MsipOffset + bus_addr_t'(4 * h)) begin
          msip_q[h] <= req_i.wdata[0];
        end
        if (off == MtimecmpOffset + bus_addr_t'(8 * h)) begin
          mtimecmp_q[h].w.lo <= req_i.wdata;
        end
        if (off == MtimecmpOffset + bus_addr_t'(8 * h + 4)) begin
          mtimecmp_q[h].w.hi <= req_i.wdata;
        end
      end
    end
  end

  // mtime, a bus write beats a tick in the same cycle
  always_comb begin
    mtime_d = mtime_q;
    if (mtime_lo_wr) begin
      mtime_d.w.lo = req_i.wdata;
    end else if (mtime_hi_wr) begin
      mtime_d.w.hi = req_i.wdata;
    end else if (tick_i) begin
      mtime_d.cnt = mtime_q.cnt + 64'd1;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_d;
    end
  end

  assign ipi_o      = msip_q;
  assign mtime_o    = mtime_q;
  assign mtimecmp_o = mtimecmp_q;

endmodule

// ==== design/periph_bus_demux.sv ====
/*
 * address decoder of the control bus, steers each strobe to the clint
 * or the debug block and returns a registered response one cycle later
 */
`timescale 1ns/10ps

module periph_bus_demux
  import soc_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      ndmreset_n,
  input  bus_req_t  bus_req_i,
  input  bus_data_t clint_rdata_i,
  input  bus_data_t dbg_rdata_i,
  output bus_req_t  clint_req_o,
  output bus_req_t  dbg_req_o,
  output bus_rsp_t  bus_rsp_o
);

  logic      hit_clint;
  logic      hit_dbg;
  bus_data_t rdata_sel;
  bus_rsp_t  rsp_d;
  bus_rsp_t  rsp_q;

  // half-open region rules
  assign hit_clint = (bus_req_i.addr >= ClintBase) &&
                     (bus_req_i.addr < ClintBase + ClintLength);
  assign hit_dbg   = (bus_req_i.addr >= DebugBase) &&
                     (bus_req_i.addr < DebugBase + DebugLength);

  always_comb begin
    clint_req_o       = bus_req_i;
    clint_req_o.valid = bus_req_i.valid & hit_clint;
    dbg_req_o         = bus_req_i;
    dbg_req_o.valid   = bus_req_i.valid & hit_dbg;
  end

  always_comb begin
    rdata_sel = '0; // unmapped reads as zero
    if (hit_clint) begin
      rdata_sel = clint_rdata_i;
    end else if (hit_dbg) begin
      rdata_sel = dbg_rdata_i;
    end
  end

  always_comb begin
    rsp_d.valid = bus_req_i.valid;
    rsp_d.err   = bus_req_i.valid & ~(hit_clint | hit_dbg);
    rsp_d.rdata = (bus_req_i.valid && !bus_req_i.we) ? rdata_sel : '0;
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign bus_rsp_o = rsp_q;

endmodule

// ==== design/soc_ctrl_pkg.sv ====
/*
 * shared widths, address map, register offsets and bus types of the
 * soc control block, taken by wildcard import in each module header
 */
package soc_ctrl_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned NrHarts = 4;
  localparam int unsigned BusAw   = 32;
  localparam int unsigned BusDw   = 32;

  typedef logic [BusAw-1:0]   bus_addr_t;
  typedef logic [BusDw-1:0]   bus_data_t;
  typedef logic [NrHarts-1:0] hart_vec_t; // one bit per hart

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam bus_addr_t ClintBase   = 32'h0200_0000;
  localparam bus_addr_t ClintLength = 32'h0001_0000;
  localparam bus_addr_t DebugBase   = 32'h0000_0000;
  localparam bus_addr_t DebugLength = 32'h0000_1000;

  // clint offsets
  localparam bus_addr_t MsipOffset     = 32'h0000_0000; // +4 per hart
  localparam bus_addr_t MtimecmpOffset = 32'h0000_4000; // +8 per hart, lo then hi
  localparam bus_addr_t MtimeOffset    = 32'h0000_bff8; // lo then hi

  // debug offsets
  localparam bus_addr_t HaltreqOffset = 32'h0000_0000;

  // harts get this long to run their boot code before a halt can land
  localparam int unsigned DmiDelCycles = 500;
  localparam int unsigned DmiCntW      = $clog2(DmiDelCycles + 1);

  // ----------------------------------------
  // bus types
  // ----------------------------------------
  typedef struct packed {
    logic      valid; // one-cycle strobe
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic      valid; // pulse, cycle after the strobe
    logic      err;   // unmapped address
    bus_data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    bus_data_t hi;
    bus_data_t lo;
  } mtime_half_t;

  // 64-bit timer word, counted and compared whole, accessed by halves
  typedef union packed {
    logic [63:0] cnt;
    mtime_half_t w;
  } mtime_word_u;

endpackage
